// File: rtl/ccc_pkg.sv
// CCC handler package with command codes, bus address constants and shared types
package ccc_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  addr_t;
  // Bit 7 set marks a direct CCC
  typedef logic [7:0]  ccc_code_t;
  typedef logic [15:0] len16_t;
  typedef logic [47:0] pid_t;
  // Wide enough for the six PID bytes
  typedef logic [2:0]  byte_cnt_t;

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxBcastData,
    RxBcastTbit,
    RxDirectByte,
    RxDirectTbit,
    RxDirectAddr,
    TxAddrAck,
    RxData,
    RxDataTbit,
    TxData,
    TxDataTbit,
    WaitBusCond,
    NextCcc,
    DoneCcc
  } frame_state_e;

  // Broadcast CCCs
  localparam ccc_code_t CccBcastEnec    = 8'h00;
  localparam ccc_code_t CccBcastDisec   = 8'h01;
  localparam ccc_code_t CccBcastRstdaa  = 8'h06;
  localparam ccc_code_t CccBcastSetmwl  = 8'h09;
  localparam ccc_code_t CccBcastSetmrl  = 8'h0A;
  localparam ccc_code_t CccBcastSetaasa = 8'h29;

  // Direct CCCs
  localparam ccc_code_t CccDirEnec      = 8'h80;
  localparam ccc_code_t CccDirDisec     = 8'h81;
  localparam ccc_code_t CccDirSetdasa   = 8'h87;
  localparam ccc_code_t CccDirSetnewda  = 8'h88;
  localparam ccc_code_t CccDirSetmwl    = 8'h89;
  localparam ccc_code_t CccDirSetmrl    = 8'h8A;
  localparam ccc_code_t CccDirGetmwl    = 8'h8B;
  localparam ccc_code_t CccDirGetmrl    = 8'h8C;
  localparam ccc_code_t CccDirGetpid    = 8'h8D;
  localparam ccc_code_t CccDirGetbcr    = 8'h8E;
  localparam ccc_code_t CccDirGetdcr    = 8'h8F;
  localparam ccc_code_t CccDirGetstatus = 8'h90;

  localparam addr_t RsvdAddr   = 7'h7E;
  // Max IBI payload size, sent as the third GETMRL byte
  localparam byte_t MrlIbiSize = 8'hFF;

  // Event bits in the ENEC/DISEC data byte
  localparam int unsigned EcIbiBit = 0;
  localparam int unsigned EcCrrBit = 1;
  localparam int unsigned EcHjBit  = 3;

endpackage

// File: rtl/ccc_frame_if.sv
// CCC frame interface between the frame sequencer and the SET/GET action stages
`timescale 1ns/1ps

interface ccc_frame_if import ccc_pkg::*; ();

  ccc_code_t ccc;
  logic      data_stb;
  byte_t     data_byte;
  logic      addr_dyn_hit;
  logic      bcast_stb;
  logic      tx_load;
  logic      tx_advance;
  // Driven by the GET responder
  byte_t     tx_byte;
  logic      tx_last;

  modport frame (
    output ccc, data_stb, data_byte, addr_dyn_hit, bcast_stb, tx_load, tx_advance,
    input  tx_byte, tx_last
  );

  modport setter (
    input ccc, data_stb, data_byte, addr_dyn_hit, bcast_stb, tx_load
  );

  modport getter (
    input  ccc, tx_load, tx_advance,
    output tx_byte, tx_last
  );

endinterface

// File: rtl/ccc_frame_fsm.sv
// CCC frame sequencer that follows the T-bit, data bytes and direct address phases
`timescale 1ns/1ps

module ccc_frame_fsm import ccc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ccc_code_t ccc_i,
  input  logic      ccc_valid_i,
  input  logic      bus_rstart_det_i,
  input  logic      bus_stop_det_i,
  input  byte_t     bus_rx_data_i,
  input  logic      bus_rx_done_i,
  input  logic      bus_tx_done_i,
  input  addr_t     target_sta_address_i,
  input  logic      target_sta_address_valid_i,
  input  addr_t     target_dyn_address_i,
  input  logic      target_dyn_address_valid_i,
  output logic      bus_rx_req_bit_o,
  output logic      bus_rx_req_byte_o,
  output logic      bus_tx_req_bit_o,
  output logic      bus_tx_req_byte_o,
  output byte_t     bus_tx_req_value_o,
  output logic      bus_tx_sel_od_pp_o,
  output logic      done_fsm_o,
  output logic      next_ccc_o,
  ccc_frame_if.frame frame
);

  frame_state_e state_q, state_d;
  ccc_code_t    ccc_q;
  addr_t        addr_q;
  logic         rnw_q;
  byte_t        rx_byte_q;
  logic         data_stb_q;
  logic         bcast_stb_q;
  logic         is_direct;
  logic         dyn_hit;
  logic         sta_hit;
  logic         our_addr;
  logic         rsvd_addr;
  logic         rsvd_byte;

  assign is_direct = ccc_q[7];
  assign dyn_hit   = target_dyn_address_valid_i && (addr_q == target_dyn_address_i);
  assign sta_hit   = target_sta_address_valid_i && (addr_q == target_sta_address_i);
  assign our_addr  = dyn_hit | sta_hit;
  assign rsvd_addr = (addr_q == RsvdAddr);
  assign rsvd_byte = (rx_byte_q == {RsvdAddr, 1'b0});

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ccc_q <= '0;
      addr_q <= '0;
      rnw_q <= 1'b0;
    end else begin
      if (state_q == WaitCcc && ccc_valid_i) begin
        ccc_q <= ccc_i;
      end
      if (state_q == RxDirectAddr && bus_rx_done_i) begin
        addr_q <= bus_rx_data_i[7:1];
        rnw_q  <= bus_rx_data_i[0];
      end
    end
  end

  // Data byte payload, held until its strobe has been consumed
  always_ff @(posedge clk_i) begin
    if ((state_q == RxData || state_q == RxBcastData) && bus_rx_done_i) begin
      rx_byte_q <= bus_rx_data_i;
    end
  end

  // Strobes fire the cycle after the closing T-bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_stb_q  <= 1'b0;
      bcast_stb_q <= 1'b0;
    end else begin
      data_stb_q  <= bus_rx_done_i && !rsvd_byte &&
                     (state_q == RxBcastTbit || state_q == RxDataTbit);
      bcast_stb_q <= bus_rx_done_i && (state_q == RxTbit) && !is_direct;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:    state_d = WaitCcc;
      WaitCcc: if (ccc_valid_i) state_d = RxTbit;
      RxTbit: begin
        if (bus_rx_done_i) state_d = is_direct ? RxDirectByte : RxBcastData;
      end
      RxBcastData: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxBcastTbit;
      end
      RxBcastTbit: if (bus_rx_done_i) state_d = RxBcastData;
      // Direct CCC waits for the repeated start, stray bytes are skipped
      RxDirectByte: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxDirectTbit;
      end
      RxDirectTbit: if (bus_rx_done_i) state_d = RxDirectByte;
      RxDirectAddr: if (bus_rx_done_i) state_d = TxAddrAck;
      TxAddrAck: begin
        if (bus_tx_done_i) begin
          if (rsvd_addr) state_d = NextCcc;
          else if (our_addr) state_d = rnw_q ? TxData : RxData;
          else state_d = WaitBusCond;
        end
      end
      RxData: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_rx_done_i) state_d = RxDataTbit;
      end
      RxDataTbit: if (bus_rx_done_i) state_d = RxData;
      TxData: begin
        if (bus_rstart_det_i) state_d = RxDirectAddr;
        else if (bus_tx_done_i) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (bus_tx_done_i) state_d = frame.tx_last ? WaitBusCond : TxData;
      end
      WaitBusCond: if (bus_rstart_det_i) state_d = RxDirectAddr;
      NextCcc: state_d = WaitCcc;
      DoneCcc: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  // Stop condition ends the frame from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_stop_det_i) begin
      state_q <= DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    bus_rx_req_bit_o   = 1'b0;
    bus_rx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_value_o = '0;
    bus_tx_sel_od_pp_o = 1'b0;
    unique case (state_q)
      RxTbit, RxBcastTbit, RxDirectTbit, RxDataTbit: bus_rx_req_bit_o = 1'b1;
      RxBcastData, RxDirectByte, RxData: bus_rx_req_byte_o = !bus_rstart_det_i;
      RxDirectAddr: bus_rx_req_byte_o = 1'b1;
      TxAddrAck: begin
        // ACK is low for our address or the reserved one, open drain
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, ~(our_addr | rsvd_addr)};
      end
      TxData: begin
        bus_tx_req_byte_o  = 1'b1;
        bus_tx_req_value_o = frame.tx_byte;
        bus_tx_sel_od_pp_o = 1'b1;
      end
      TxDataTbit: begin
        bus_tx_req_bit_o   = 1'b1;
        bus_tx_req_value_o = {7'h00, frame.tx_last};
        bus_tx_sel_od_pp_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign done_fsm_o = (state_q == DoneCcc);
  assign next_ccc_o = (state_q == NextCcc);

  assign frame.ccc          = ccc_q;
  assign frame.data_stb     = data_stb_q;
  assign frame.data_byte    = rx_byte_q;
  assign frame.addr_dyn_hit = dyn_hit;
  assign frame.bcast_stb    = bcast_stb_q;
  assign frame.tx_load      = (state_q == TxAddrAck) && bus_tx_done_i;
  assign frame.tx_advance   = (state_q == TxDataTbit) && bus_tx_done_i;

endmodule

// File: rtl/ccc_set_decoder.sv
// CCC SET decoder that turns received data bytes into length, event and address updates
`timescale 1ns/1ps

module ccc_set_decoder import ccc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  ccc_frame_if.setter frame,
  input  addr_t  target_sta_address_i,
  output logic   set_mwl_o,
  output len16_t mwl_o,
  output logic   set_mrl_o,
  output len16_t mrl_o,
  output logic   enec_ibi_o,
  output logic   enec_crr_o,
  output logic   enec_hj_o,
  output logic   disec_ibi_o,
  output logic   disec_crr_o,
  output logic   disec_hj_o,
  output logic   rstdaa_o,
  output addr_t  set_dasa_o,
  output logic   set_dasa_valid_o,
  output logic   set_newda_o,
  output addr_t  newda_o
);

  byte_cnt_t cnt_q;
  byte_t     len_hi_q;
  logic      first_byte;
  logic      second_byte;
  logic      is_mwl;
  logic      is_mrl;
  logic      is_enec;
  logic      is_disec;

  assign first_byte  = frame.data_stb && (cnt_q == 3'd0);
  assign second_byte = frame.data_stb && (cnt_q == 3'd1);

  assign is_mwl   = (frame.ccc == CccBcastSetmwl) || (frame.ccc == CccDirSetmwl);
  assign is_mrl   = (frame.ccc == CccBcastSetmrl) || (frame.ccc == CccDirSetmrl);
  assign is_enec  = (frame.ccc == CccBcastEnec) || (frame.ccc == CccDirEnec);
  assign is_disec = (frame.ccc == CccBcastDisec) || (frame.ccc == CccDirDisec);

  // Byte index within the current CCC or direct target, saturating
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (frame.bcast_stb || frame.tx_load) begin
      cnt_q <= '0;
    end else if (frame.data_stb && cnt_q != '1) begin
      cnt_q <= cnt_q + 3'd1;
    end
  end

  // Payload bytes and addresses
  always_ff @(posedge clk_i) begin
    if (first_byte) begin
      len_hi_q <= frame.data_byte;
    end
    if (first_byte && frame.ccc == CccDirSetdasa) begin
      set_dasa_o <= frame.data_byte[7:1];
    end else if (frame.bcast_stb && frame.ccc == CccBcastSetaasa) begin
      set_dasa_o <= target_sta_address_i;
    end
    if (first_byte && frame.ccc == CccDirSetnewda && frame.addr_dyn_hit) begin
      newda_o <= frame.data_byte[7:1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_o        <= 1'b0;
      set_mrl_o        <= 1'b0;
      mwl_o            <= '0;
      mrl_o            <= '0;
      rstdaa_o         <= 1'b0;
      set_dasa_valid_o <= 1'b0;
      set_newda_o      <= 1'b0;
    end else begin
      // High byte arrives first, the low byte completes the length
      set_mwl_o <= second_byte && is_mwl;
      set_mrl_o <= second_byte && is_mrl;
      if (second_byte && is_mwl) begin
        mwl_o <= {len_hi_q, frame.data_byte};
      end
      if (second_byte && is_mrl) begin
        mrl_o <= {len_hi_q, frame.data_byte};
      end
      rstdaa_o         <= frame.bcast_stb && (frame.ccc == CccBcastRstdaa);
      set_dasa_valid_o <= (first_byte && frame.ccc == CccDirSetdasa) ||
                          (frame.bcast_stb && frame.ccc == CccBcastSetaasa);
      set_newda_o      <= first_byte && frame.ccc == CccDirSetnewda && frame.addr_dyn_hit;
    end
  end

  // Event enable and disable levels
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_ibi_o  <= 1'b0;
      enec_crr_o  <= 1'b0;
      enec_hj_o   <= 1'b0;
      disec_ibi_o <= 1'b0;
      disec_crr_o <= 1'b0;
      disec_hj_o  <= 1'b0;
    end else if (first_byte) begin
      if (is_enec) begin
        enec_ibi_o <= frame.data_byte[EcIbiBit];
        enec_crr_o <= frame.data_byte[EcCrrBit];
        enec_hj_o  <= frame.data_byte[EcHjBit];
      end
      if (is_disec) begin
        disec_ibi_o <= frame.data_byte[EcIbiBit];
        disec_crr_o <= frame.data_byte[EcCrrBit];
        disec_hj_o  <= frame.data_byte[EcHjBit];
      end
    end
  end

endmodule

// File: rtl/ccc_get_responder.sv
// CCC GET responder that counts response bytes and picks each one from the CSR inputs
`timescale 1ns/1ps

module ccc_get_responder import ccc_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  ccc_frame_if.getter frame,
  input  byte_t  get_bcr_i,
  input  byte_t  get_dcr_i,
  input  len16_t get_mwl_i,
  input  len16_t get_mrl_i,
  input  pid_t   get_pid_i,
  input  len16_t get_status_fmt1_i
);

  byte_cnt_t remain_q;
  byte_cnt_t load_len;

  always_comb begin
    unique case (frame.ccc)
      CccDirGetbcr, CccDirGetdcr:    load_len = 3'd1;
      CccDirGetmwl, CccDirGetstatus: load_len = 3'd2;
      CccDirGetmrl:                  load_len = 3'd3;
      CccDirGetpid:                  load_len = 3'd6;
      default:                       load_len = 3'd0;
    endcase
  end

  // Bytes left including the one on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
    end else if (frame.tx_load) begin
      remain_q <= load_len;
    end else if (frame.tx_advance && remain_q != '0) begin
      remain_q <= remain_q - 3'd1;
    end
  end

  // Most significant byte goes out first
  always_comb begin
    frame.tx_byte = '0;
    unique case (frame.ccc)
      CccDirGetbcr: frame.tx_byte = get_bcr_i;
      CccDirGetdcr: frame.tx_byte = get_dcr_i;
      CccDirGetmwl: frame.tx_byte = (remain_q == 3'd2) ? get_mwl_i[15:8] : get_mwl_i[7:0];
      CccDirGetstatus: begin
        frame.tx_byte = (remain_q == 3'd2) ? get_status_fmt1_i[15:8] : get_status_fmt1_i[7:0];
      end
      CccDirGetmrl: begin
        case (remain_q)
          3'd3:    frame.tx_byte = get_mrl_i[15:8];
          3'd2:    frame.tx_byte = get_mrl_i[7:0];
          default: frame.tx_byte = MrlIbiSize;
        endcase
      end
      CccDirGetpid: begin
        case (remain_q)
          3'd6:    frame.tx_byte = get_pid_i[47:40];
          3'd5:    frame.tx_byte = get_pid_i[39:32];
          3'd4:    frame.tx_byte = get_pid_i[31:24];
          3'd3:    frame.tx_byte = get_pid_i[23:16];
          3'd2:    frame.tx_byte = get_pid_i[15:8];
          default: frame.tx_byte = get_pid_i[7:0];
        endcase
      end
      default: begin
      end
    endcase
  end

  // Also high for an unsupported code so the first T-bit ends the read
  assign frame.tx_last = (remain_q <= 3'd1);

endmodule

// File: rtl/ccc_target_top.sv
// CCC target handler top level joining the frame sequencer with the SET and GET stages
`timescale 1ns/1ps

module ccc_target_top import ccc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ccc_code_t ccc_i,
  input  logic      ccc_valid_i,
  input  logic      bus_rstart_det_i,
  input  logic      bus_stop_det_i,
  input  byte_t     bus_rx_data_i,
  input  logic      bus_rx_done_i,
  input  logic      bus_tx_done_i,
  input  addr_t     target_sta_address_i,
  input  logic      target_sta_address_valid_i,
  input  addr_t     target_dyn_address_i,
  input  logic      target_dyn_address_valid_i,
  output logic      bus_rx_req_bit_o,
  output logic      bus_rx_req_byte_o,
  output logic      bus_tx_req_bit_o,
  output logic      bus_tx_req_byte_o,
  output byte_t     bus_tx_req_value_o,
  output logic      bus_tx_sel_od_pp_o,
  output logic      done_fsm_o,
  output logic      next_ccc_o,
  output logic      set_mwl_o,
  output len16_t    mwl_o,
  output logic      set_mrl_o,
  output len16_t    mrl_o,
  output logic      enec_ibi_o,
  output logic      enec_crr_o,
  output logic      enec_hj_o,
  output logic      disec_ibi_o,
  output logic      disec_crr_o,
  output logic      disec_hj_o,
  output logic      rstdaa_o,
  output addr_t     set_dasa_o,
  output logic      set_dasa_valid_o,
  output logic      set_newda_o,
  output addr_t     newda_o,
  input  byte_t     get_bcr_i,
  input  byte_t     get_dcr_i,
  input  len16_t    get_mwl_i,
  input  len16_t    get_mrl_i,
  input  pid_t      get_pid_i,
  input  len16_t    get_status_fmt1_i
);

  ccc_frame_if frame_if ();

  ccc_frame_fsm u_frame_fsm (
    .clk_i, .rst_ni, .ccc_i, .ccc_valid_i, .bus_rstart_det_i, .bus_stop_det_i,
    .bus_rx_data_i, .bus_rx_done_i, .bus_tx_done_i,
    .target_sta_address_i, .target_sta_address_valid_i,
    .target_dyn_address_i, .target_dyn_address_valid_i,
    .bus_rx_req_bit_o, .bus_rx_req_byte_o, .bus_tx_req_bit_o, .bus_tx_req_byte_o,
    .bus_tx_req_value_o, .bus_tx_sel_od_pp_o, .done_fsm_o, .next_ccc_o,
    .frame(frame_if)
  );

  ccc_set_decoder u_set_decoder (
    .clk_i, .rst_ni, .frame(frame_if), .target_sta_address_i,
    .set_mwl_o, .mwl_o, .set_mrl_o, .mrl_o,
    .enec_ibi_o, .enec_crr_o, .enec_hj_o, .disec_ibi_o, .disec_crr_o, .disec_hj_o,
    .rstdaa_o, .set_dasa_o, .set_dasa_valid_o, .set_newda_o, .newda_o
  );

  ccc_get_responder u_get_responder (
    .clk_i, .rst_ni, .frame(frame_if),
    .get_bcr_i, .get_dcr_i, .get_mwl_i, .get_mrl_i, .get_pid_i, .get_status_fmt1_i
  );

endmodule

// File: sim/ccc_target_sva.sv
// CCC target bus checks on request levels, stop handling and the done pulse
`timescale 1ns/1ps

module ccc_target_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic bus_rx_req_bit_i,
  input logic bus_rx_req_byte_i,
  input logic bus_tx_req_bit_i,
  input logic bus_tx_req_byte_i,
  input logic bus_stop_det_i,
  input logic done_fsm_i
);

  int unsigned fail_cnt = 0;

  // The bus is serial, one direction at a time
  a_rx_tx_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_rx_req_bit_i || bus_rx_req_byte_i) && (bus_tx_req_bit_i || bus_tx_req_byte_i)))
    else begin
      $error("RX and TX requests are high in the same cycle");
      fail_cnt++;
    end

  a_done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_fsm_i |=> !done_fsm_i)
    else begin
      $error("done_fsm_o is high for more than one cycle");
      fail_cnt++;
    end

  a_stop_gives_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stop_det_i |=> done_fsm_i)
    else begin
      $error("Bus stop is not followed by done_fsm_o");
      fail_cnt++;
    end

endmodule

bind ccc_target_top ccc_target_sva u_ccc_target_sva (
  .clk_i,
  .rst_ni,
  .bus_rx_req_bit_i (bus_rx_req_bit_o),
  .bus_rx_req_byte_i(bus_rx_req_byte_o),
  .bus_tx_req_bit_i (bus_tx_req_bit_o),
  .bus_tx_req_byte_i(bus_tx_req_byte_o),
  .bus_stop_det_i,
  .done_fsm_i       (done_fsm_o)
);

// File: sim/tb_ccc_target.sv
// CCC target testbench with a bus agent, random CCC frames and a reference model
`timescale 1ns/1ps

module tb_ccc_target import ccc_pkg::*; ();

  localparam int NumTests  = 60;
  localparam int MaxWait   = 200;
  localparam int ReqRxBit  = 0;
  localparam int ReqRxByte = 1;
  localparam int ReqTxBit  = 2;
  localparam int ReqTxByte = 3;
  localparam int DoneFsm   = 4;
  localparam addr_t StaAddr = 7'h4B;
  localparam addr_t DynAddr = 7'h12;

  logic      clk_i;
  logic      rst_ni;
  ccc_code_t ccc_i;
  logic      ccc_valid_i;
  logic      bus_rstart_det_i;
  logic      bus_stop_det_i;
  byte_t     bus_rx_data_i;
  logic      bus_rx_done_i;
  logic      bus_tx_done_i;
  addr_t     target_sta_address_i;
  logic      target_sta_address_valid_i;
  addr_t     target_dyn_address_i;
  logic      target_dyn_address_valid_i;
  logic      bus_rx_req_bit_o, bus_rx_req_byte_o, bus_tx_req_bit_o, bus_tx_req_byte_o;
  byte_t     bus_tx_req_value_o;
  logic      bus_tx_sel_od_pp_o;
  logic      done_fsm_o, next_ccc_o;
  logic      set_mwl_o, set_mrl_o;
  len16_t    mwl_o, mrl_o;
  logic      enec_ibi_o, enec_crr_o, enec_hj_o;
  logic      disec_ibi_o, disec_crr_o, disec_hj_o;
  logic      rstdaa_o, set_dasa_valid_o, set_newda_o;
  addr_t     set_dasa_o, newda_o;
  byte_t     get_bcr_i, get_dcr_i;
  len16_t    get_mwl_i, get_mrl_i, get_status_fmt1_i;
  pid_t      get_pid_i;

  logic [31:0] rng_state = 32'h16b99212;
  string       tname;
  int          test_idx;
  int          test_errs;
  int          err_cnt;
  int          failed_tests;
  int          sva_fails;
  logic        timed_out;
  // Model state with event levels packed as {hj, crr, ibi}
  len16_t      exp_mwl, exp_mrl;
  logic [2:0]  exp_enec, exp_disec;
  addr_t       exp_dasa, exp_newda;
  int          pulse_cnt[7];
  int          exp_cnt[7];
  string       pulse_name[7] = '{"set_mwl_o", "set_mrl_o", "set_dasa_valid_o",
                                 "set_newda_o", "rstdaa_o", "next_ccc_o", "done_fsm_o"};

  ccc_target_top u_ccc_target_top (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (set_mwl_o) pulse_cnt[0] = pulse_cnt[0] + 1;
    if (set_mrl_o) pulse_cnt[1] = pulse_cnt[1] + 1;
    if (set_dasa_valid_o) pulse_cnt[2] = pulse_cnt[2] + 1;
    if (set_newda_o) pulse_cnt[3] = pulse_cnt[3] + 1;
    if (rstdaa_o) pulse_cnt[4] = pulse_cnt[4] + 1;
    if (next_ccc_o) pulse_cnt[5] = pulse_cnt[5] + 1;
    if (done_fsm_o) pulse_cnt[6] = pulse_cnt[6] + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    return rand32() % n;
  endfunction

  function automatic byte_t rand_data();
    byte_t b;
    b = byte_t'(rand32());
    // FCh reads as the reserved address and carries no data strobe
    if (b == {RsvdAddr, 1'b0}) b = 8'hFD;
    return b;
  endfunction

  function automatic logic req_level(input int which);
    case (which)
      ReqRxBit:  return bus_rx_req_bit_o;
      ReqRxByte: return bus_rx_req_byte_o;
      ReqTxBit:  return bus_tx_req_bit_o;
      ReqTxByte: return bus_tx_req_byte_o;
      default:   return done_fsm_o;
    endcase
  endfunction

  // Expected GET response with the most significant byte first
  function automatic int get_len(input ccc_code_t code);
    case (code)
      CccDirGetbcr, CccDirGetdcr:    return 1;
      CccDirGetmwl, CccDirGetstatus: return 2;
      CccDirGetmrl:                  return 3;
      default:                       return 6;
    endcase
  endfunction

  function automatic byte_t get_byte(input ccc_code_t code, input int idx);
    case (code)
      CccDirGetbcr:    return get_bcr_i;
      CccDirGetdcr:    return get_dcr_i;
      CccDirGetmwl:    return (idx == 0) ? get_mwl_i[15:8] : get_mwl_i[7:0];
      CccDirGetstatus: return (idx == 0) ? get_status_fmt1_i[15:8] : get_status_fmt1_i[7:0];
      CccDirGetmrl:    return (idx == 0) ? get_mrl_i[15:8] : (idx == 1) ? get_mrl_i[7:0] : 8'hFF;
      default:         return get_pid_i[47 - 8 * idx -: 8];
    endcase
  endfunction

  task automatic report_error(input string what, input string exp, input string act);
    $display("[ERROR] %s %s: expected %s, actual %s", tname, what, exp, act);
    err_cnt++;
    test_errs++;
  endtask

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    if (act !== exp) report_error(what, $sformatf("%02h", exp), $sformatf("%02h", act));
  endtask

  task automatic check_len(input string what, input len16_t exp, input len16_t act);
    if (act !== exp) report_error(what, $sformatf("%04h", exp), $sformatf("%04h", act));
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (act !== exp) report_error(what, $sformatf("%02h", exp), $sformatf("%02h", act));
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) report_error(what, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) report_error(what, $sformatf("%0d pulses", exp), $sformatf("%0d", act));
  endtask

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_for(input int which, input string what);
    int n;
    n = 0;
    while (!timed_out && !req_level(which)) begin
      step();
      n++;
      if (n > MaxWait) begin
        $display("Timeout in %s while waiting for %s", tname, what);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic bus_rx(input int which, input string what, input byte_t data);
    wait_for(which, what);
    if (timed_out) return;
    repeat (rand_below(4)) step();
    bus_rx_data_i = data;
    bus_rx_done_i = 1'b1;
    step();
    bus_rx_done_i = 1'b0;
  endtask

  // Push-pull select is returned with the value sent
  task automatic bus_tx(input int which, input string what, output byte_t value,
                        output logic pp);
    value = '0;
    pp    = 1'b0;
    wait_for(which, what);
    if (timed_out) return;
    repeat (rand_below(4)) step();
    value = bus_tx_req_value_o;
    pp    = bus_tx_sel_od_pp_o;
    bus_tx_done_i = 1'b1;
    step();
    bus_tx_done_i = 1'b0;
  endtask

  task automatic send_ccc(input ccc_code_t code);
    ccc_i       = code;
    ccc_valid_i = 1'b1;
    wait_for(ReqRxBit, "CCC accept");
    ccc_valid_i = 1'b0;
  endtask

  task automatic send_tbit();
    bus_rx(ReqRxBit, "T-bit", byte_t'(rand_below(2) << 7));
  endtask

  // Repeated start, then the target address and its ACK
  task automatic address_phase(input addr_t addr, input logic rnw, input logic exp_ack);
    byte_t v;
    logic  pp;
    wait_for(ReqRxByte, "direct byte request");
    if (timed_out) return;
    bus_rstart_det_i = 1'b1;
    step();
    bus_rstart_det_i = 1'b0;
    bus_rx(ReqRxByte, "address", {addr, rnw});
    bus_tx(ReqTxBit, "address ACK", v, pp);
    check_bit("ack", exp_ack, v[0]);
    // ACK is driven open drain
    check_bit("ack push-pull", 1'b0, pp);
  endtask

  task automatic end_frame();
    repeat (rand_below(4)) step();
    bus_stop_det_i = 1'b1;
    step();
    bus_stop_det_i = 1'b0;
    wait_for(DoneFsm, "done_fsm_o");
    repeat (3) step();
  endtask

  task automatic write_frame(input ccc_code_t code, input addr_t addr, input byte_t data[$]);
    send_ccc(code);
    send_tbit();
    if (code[7]) address_phase(addr, 1'b0, 1'b0);
    foreach (data[i]) begin
      bus_rx(ReqRxByte, "data byte", data[i]);
      send_tbit();
    end
    end_frame();
  endtask

  function automatic addr_t our_addr();
    return rand_below(2) ? StaAddr : DynAddr;
  endfunction

  task automatic get_response_test();
    ccc_code_t code;
    byte_t     v;
    logic      pp;
    int        n;
    code = ccc_code_t'(8'h8B + rand_below(6));
    tname = $sformatf("%0d_get_%02h", test_idx, code);
    get_bcr_i = byte_t'(rand32());
    get_dcr_i = byte_t'(rand32());
    get_mwl_i = len16_t'(rand32());
    get_mrl_i = len16_t'(rand32());
    get_status_fmt1_i = len16_t'(rand32());
    get_pid_i = {rand32(), 16'(rand32())};
    n = get_len(code);
    send_ccc(code);
    send_tbit();
    address_phase(DynAddr, 1'b1, 1'b0);
    for (int i = 0; i < n; i++) begin
      bus_tx(ReqTxByte, "GET byte", v, pp);
      check_byte($sformatf("byte %0d", i), get_byte(code, i), v);
      check_bit($sformatf("byte %0d push-pull", i), 1'b1, pp);
      bus_tx(ReqTxBit, "GET T-bit", v, pp);
      check_bit($sformatf("T-bit %0d", i), i == n - 1, v[0]);
      check_bit($sformatf("T-bit %0d push-pull", i), 1'b1, pp);
    end
    end_frame();
  endtask

  task automatic set_length_test();
    ccc_code_t code;
    byte_t     q[$];
    logic      is_mrl;
    is_mrl = rand_below(2);
    code = is_mrl ? CccBcastSetmrl : CccBcastSetmwl;
    code[7] = rand_below(2);
    tname = $sformatf("%0d_set_len_%02h", test_idx, code);
    q.push_back(rand_data());
    q.push_back(rand_data());
    write_frame(code, our_addr(), q);
    if (is_mrl) begin
      exp_mrl = {q[0], q[1]};
      exp_cnt[1] = 1;
    end else begin
      exp_mwl = {q[0], q[1]};
      exp_cnt[0] = 1;
    end
  endtask

  task automatic event_bits_test();
    ccc_code_t code;
    byte_t     q[$];
    code = rand_below(2) ? CccBcastDisec : CccBcastEnec;
    code[7] = rand_below(2);
    tname = $sformatf("%0d_events_%02h", test_idx, code);
    q.push_back(rand_data());
    write_frame(code, our_addr(), q);
    if (code[0]) exp_disec = {q[0][3], q[0][1], q[0][0]};
    else exp_enec = {q[0][3], q[0][1], q[0][0]};
  endtask

  task automatic address_assign_test();
    byte_t q[$];
    int    sel;
    sel = rand_below(4);
    tname = $sformatf("%0d_addr_set_%0d", test_idx, sel);
    if (sel < 2) q.push_back(rand_data());
    case (sel)
      0: begin
        write_frame(CccDirSetdasa, StaAddr, q);
        exp_dasa = q[0][7:1];
        exp_cnt[2] = 1;
      end
      1: begin
        write_frame(CccDirSetnewda, DynAddr, q);
        exp_newda = q[0][7:1];
        exp_cnt[3] = 1;
      end
      2: begin
        write_frame(CccBcastSetaasa, StaAddr, q);
        exp_dasa = StaAddr;
        exp_cnt[2] = 1;
      end
      default: begin
        write_frame(CccBcastRstdaa, StaAddr, q);
        exp_cnt[4] = 1;
      end
    endcase
  endtask

  // Foreign direct address gets a NACK while the reserved one hands back
  task automatic other_address_test();
    ccc_code_t code;
    addr_t     addr;
    logic      rsvd;
    code = ccc_code_t'(8'h80 + rand_below(17));
    rsvd = rand_below(2);
    do begin
      addr = addr_t'(rand32());
    end while (addr == StaAddr || addr == DynAddr || addr == RsvdAddr);
    tname = $sformatf("%0d_%s_%02h", test_idx, rsvd ? "reserved" : "foreign", code);
    send_ccc(code);
    send_tbit();
    if (rsvd) begin
      address_phase(RsvdAddr, 1'b0, 1'b0);
      exp_cnt[5] = 1;
    end else begin
      address_phase(addr, 1'(rand_below(2)), 1'b1);
    end
    end_frame();
  endtask

  task automatic stop_test();
    int k;
    k = rand_below(3);
    tname = $sformatf("%0d_stop_%0d", test_idx, k);
    send_ccc(CccBcastSetmwl);
    if (k > 0) send_tbit();
    if (k > 1) bus_rx(ReqRxByte, "data byte", rand_data());
    end_frame();
  endtask

  task automatic check_outputs();
    check_len("mwl_o", exp_mwl, mwl_o);
    check_len("mrl_o", exp_mrl, mrl_o);
    check_bit("enec_ibi_o", exp_enec[0], enec_ibi_o);
    check_bit("enec_crr_o", exp_enec[1], enec_crr_o);
    check_bit("enec_hj_o", exp_enec[2], enec_hj_o);
    check_bit("disec_ibi_o", exp_disec[0], disec_ibi_o);
    check_bit("disec_crr_o", exp_disec[1], disec_crr_o);
    check_bit("disec_hj_o", exp_disec[2], disec_hj_o);
    check_addr("set_dasa_o", exp_dasa, set_dasa_o);
    check_addr("newda_o", exp_newda, newda_o);
    foreach (exp_cnt[i]) check_count(pulse_name[i], exp_cnt[i], pulse_cnt[i]);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    ccc_i = '0;
    ccc_valid_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    bus_rx_data_i = '0;
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    target_sta_address_i = StaAddr;
    target_sta_address_valid_i = 1'b1;
    target_dyn_address_i = DynAddr;
    target_dyn_address_valid_i = 1'b1;
    get_bcr_i = '0;
    get_dcr_i = '0;
    get_mwl_i = '0;
    get_mrl_i = '0;
    get_pid_i = '0;
    get_status_fmt1_i = '0;
    exp_mwl = '0;
    exp_mrl = '0;
    exp_enec = '0;
    exp_disec = '0;
    // Address outputs stay unknown until first written
    exp_dasa = 'x;
    exp_newda = 'x;
    err_cnt = 0;
    failed_tests = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    step();
    for (test_idx = 0; test_idx < NumTests && !timed_out; test_idx++) begin
      test_errs = 0;
      foreach (pulse_cnt[i]) begin
        pulse_cnt[i] = 0;
        exp_cnt[i] = 0;
      end
      exp_cnt[6] = 1;
      case (test_idx % 6)
        0: get_response_test();
        1: set_length_test();
        2: event_bits_test();
        3: address_assign_test();
        4: other_address_test();
        default: stop_test();
      endcase
      check_outputs();
      if (test_errs != 0 || timed_out) failed_tests++;
      $display("%-24s %s", tname, (test_errs == 0 && !timed_out) ? "ok" : "FAILED");
    end
    sva_fails = u_ccc_target_top.u_ccc_target_sva.fail_cnt;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             test_idx, failed_tests, err_cnt, sva_fails);
    if (!timed_out && err_cnt == 0 && sva_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/ccc_pkg.sv
rtl/ccc_frame_if.sv
rtl/ccc_frame_fsm.sv
rtl/ccc_set_decoder.sv
rtl/ccc_get_responder.sv
rtl/ccc_target_top.sv
sim/ccc_target_sva.sv
sim/tb_ccc_target.sv
